//--- tb.f
verilog/warp_fetch_pkg.sv
verilog/warp_pc_table.sv
verilog/fetch_scheduler.sv
verilog/inst_fetch.sv
verilog/inst_buffer.sv
verilog/fetch_frontend.sv
tb/fetch_checker.sv
tb/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_top -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

# Pass only when the testbench printed its pass line
grep -qx "TEST OK" sim.log

//--- tb/tb_top.sv
////////////////////
// Fetch front end testbench
// Seeded warp launches and issue back-pressure around the DUT
////////////////////
`timescale 1ns/100ps

module tb_top;
  import warp_fetch_pkg::*;

  localparam int launch_limit = 4000;
  localparam int drain_limit  = 10000;

  logic    clk;
  logic    rst_n;
  logic    launch_valid;
  logic    launch_ready;
  launch_t launch;
  logic    issue_valid;
  logic    issue_ready;
  inst_t   issue;
  logic    fair_en;
  int      ready_mode;
  int      stall_left = 0;
  int      tb_err;
  int      chk_err;
  int      issued;
  int      pending;
  int      waited;

  fetch_frontend UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .launch_valid (launch_valid),
    .launch_ready (launch_ready),
    .launch       (launch),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue        (issue)
  );

  fetch_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .launch_valid (launch_valid),
    .launch_ready (launch_ready),
    .launch       (launch),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue        (issue),
    .fair_en      (fair_en),
    .err_cnt      (chk_err),
    .issued       (issued),
    .pending      (pending)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // Issue back-pressure
  // 1 mostly ready, 2 coin toss, 3 long stalls
  always @(posedge clk) begin
    case (ready_mode)
      1: issue_ready <= ($urandom % 8) != 0;
      2: issue_ready <= ($urandom % 2) != 0;
      3: begin
        if (stall_left > 0) begin
          issue_ready <= 1'b0;
          stall_left  <= stall_left - 1;
        end else begin
          issue_ready <= 1'b1;
          if ($urandom % 4 == 0) begin
            stall_left <= 16 + int'($urandom % 32);
          end
        end
      end
      default: issue_ready <= 1'b1;
    endcase
  end

  // Word aligned start address
  function automatic pc_t random_pc();
    return pc_t'($urandom) & ~pc_t'(3);
  endfunction

  function automatic int random_count();
    return 1 + int'($urandom % 8);
  endfunction

  // Hold a launch until the handshake, returns cycles spent waiting
  task automatic launch_warp(input warp_num_t w, input pc_t pc, input int cnt, output int n);
    logic taken;
    n     = 0;
    taken = 1'b0;
    launch_valid   <= 1'b1;
    launch.warp     <= w;
    launch.start_pc <= pc;
    launch.count    <= cnt_width'(cnt);
    while (!taken && n < launch_limit) begin
      @(posedge clk);
      if (launch_ready) begin
        taken = 1'b1;
      end else begin
        n++;
      end
    end
    launch_valid <= 1'b0;
    if (!taken) begin
      $display("Timeout: launch of warp %0d never accepted", w);
      tb_err++;
    end
  endtask

  // Wait until every launched word has issued
  task automatic drain_all();
    int   n;
    logic idle;
    n    = 0;
    idle = 1'b0;
    while (!idle && n < drain_limit) begin
      @(posedge clk);
      n++;
      idle = (pending == 0) && !issue_valid;
    end
    if (!idle) begin
      $display("Timeout: %0d launched instructions never issued", pending);
      tb_err++;
    end
  endtask

  task automatic finish_run();
    $display("Closing: %0d checker errors, %0d testbench errors, %0d issued",
             chk_err, tb_err, issued);
    if (chk_err == 0 && tb_err == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    launch_valid = 1'b0;
    launch       = '0;
    issue_ready  = 1'b0;
    fair_en      = 1'b0;
    ready_mode   = 0;
    tb_err       = 0;
    void'($urandom(32'h2080));
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // One launch per warp, light back-pressure
    ready_mode <= 2;
    for (int w = 0; w < warp_num; w++) begin
      launch_warp(warp_num_t'(w), random_pc(), random_count(), waited);
    end
    drain_all();
    // All four warps at full length for the fairness window
    ready_mode <= 1;
    fair_en    <= 1'b1;
    for (int w = 0; w < warp_num; w++) begin
      launch_warp(warp_num_t'(w), random_pc(), 8, waited);
    end
    drain_all();
    fair_en <= 1'b0;
    // Long stalls fill the FIFOs
    ready_mode <= 3;
    repeat (12) begin
      launch_warp(warp_num_t'($urandom % warp_num), random_pc(), random_count(), waited);
    end
    drain_all();
    // Finished warps take a new launch at once
    ready_mode <= 2;
    for (int w = 0; w < warp_num; w++) begin
      launch_warp(warp_num_t'(w), random_pc(), random_count(), waited);
      if (waited != 0) begin
        $display("Relaunch of finished warp %0d waited %0d cycles", w, waited);
        tb_err++;
      end
    end
    // Mixed traffic, busy warps hold their relaunch
    repeat (20) begin
      launch_warp(warp_num_t'($urandom % warp_num), random_pc(), random_count(), waited);
    end
    drain_all();
    finish_run();
  end

endmodule

//--- tb/fetch_checker.sv
////////////////////
// Fetch checker
// Per-warp model of launched work that checks every issued word
////////////////////
`timescale 1ns/100ps

module fetch_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    launch_valid,
  input  logic                    launch_ready,
  input  warp_fetch_pkg::launch_t launch,
  input  logic                    issue_valid,
  input  logic                    issue_ready,
  input  warp_fetch_pkg::inst_t   issue,
  input  logic                    fair_en,
  output int                      err_cnt,
  output int                      issued,
  output int                      pending
);
  import warp_fetch_pkg::*;

  // Ring per warp deep enough for a relaunch queued behind old entries
  localparam int slots    = 64;
  localparam int fair_gap = buf_depth + 2;

  pc_t   exp_pc   [warp_num][slots];
  logic  exp_last [warp_num][slots];
  int    head     [warp_num];
  int    tail     [warp_num];
  int    fair_cnt [warp_num];
  int    rst_edges;
  logic  after_rst;
  logic  stalled;
  inst_t held_issue;

  // Exit on the last word, else pc[3:2] selects alu, mem, ctrl or alu
  function automatic inst_t expected_inst(input warp_num_t w, input pc_t pc, input logic fin);
    inst_t r;
    r.warp = w;
    r.pc   = pc;
    r.imm  = ~pc[11:0];
    if (fin) begin
      r.opcode = op_exit;
    end else if (pc[3:2] == 2'd1) begin
      r.opcode = op_mem;
    end else if (pc[3:2] == 2'd2) begin
      r.opcode = op_ctrl;
    end else begin
      r.opcode = op_alu;
    end
    return r;
  endfunction

  // Idle outputs expected in and right after reset
  task automatic check_idle();
    if (issue_valid !== 1'b0) begin
      $display("ERR issue_valid after reset: got %h expected 0", issue_valid);
      err_cnt++;
    end
    if (launch_ready !== 1'b1) begin
      $display("ERR launch_ready after reset: got %h expected 1", launch_ready);
      err_cnt++;
    end
  endtask

  // Instructions launched but not yet issued
  always_comb begin
    pending = 0;
    for (int v = 0; v < warp_num; v++) begin
      pending = pending + (tail[v] - head[v]);
    end
  end

  always @(posedge clk) begin : monitor
    int    w;
    int    n;
    inst_t exp;
    if (!rst_n) begin
      // First edge may race the async reset
      if (rst_edges > 0) begin
        check_idle();
      end
      rst_edges++;
      after_rst <= 1'b1;
      stalled   <= 1'b0;
      for (int v = 0; v < warp_num; v++) begin
        head[v]     <= 0;
        tail[v]     <= 0;
        fair_cnt[v] <= 0;
      end
    end else begin
      if (after_rst) begin
        check_idle();
      end
      after_rst <= 1'b0;
      // A stalled offer must stay put
      if (stalled && !issue_valid) begin
        $display("ERR issue_valid while stalled: got 0 expected 1");
        err_cnt++;
      end else if (stalled && issue !== held_issue) begin
        $display("ERR issue while stalled: got %h expected %h", issue, held_issue);
        err_cnt++;
      end
      stalled    <= issue_valid && !issue_ready;
      held_issue <= issue;
      // Launch adds count words with the pc stepping by 4
      if (launch_valid && launch_ready) begin
        w = int'(launch.warp);
        n = int'(launch.count);
        for (int i = 0; i < n; i++) begin
          exp_pc[w][(tail[w] + i) % slots]   = launch.start_pc + pc_t'(4 * i);
          exp_last[w][(tail[w] + i) % slots] = (i == n - 1);
        end
        tail[w] <= tail[w] + n;
      end
      if (issue_valid && issue_ready) begin
        w = int'(issue.warp);
        issued++;
        if (head[w] == tail[w]) begin
          $display("Warp %0d issued pc %h with nothing outstanding", w, issue.pc);
          err_cnt++;
        end else begin
          exp = expected_inst(issue.warp, exp_pc[w][head[w] % slots],
                              exp_last[w][head[w] % slots]);
          if (issue.pc !== exp.pc) begin
            $display("ERR issue.pc warp %0d: got %h expected %h", w, issue.pc, exp.pc);
            err_cnt++;
          end
          if (issue.opcode !== exp.opcode) begin
            $display("ERR issue.opcode warp %0d: got %h expected %h",
                     w, issue.opcode, exp.opcode);
            err_cnt++;
          end
          if (issue.imm !== exp.imm) begin
            $display("ERR issue.imm warp %0d: got %h expected %h", w, issue.imm, exp.imm);
            err_cnt++;
          end
          head[w] <= head[w] + 1;
        end
        // No warp runs far ahead of one that still has work
        if (fair_en) begin
          for (int v = 0; v < warp_num; v++) begin
            if (v != w && tail[v] != head[v] && fair_cnt[w] + 1 - fair_cnt[v] >= fair_gap) begin
              $display("Warp %0d ran %0d issues ahead of waiting warp %0d",
                       w, fair_cnt[w] + 1 - fair_cnt[v], v);
              err_cnt++;
            end
          end
          fair_cnt[w] <= fair_cnt[w] + 1;
        end
      end
      if (!fair_en) begin
        for (int v = 0; v < warp_num; v++) begin
          fair_cnt[v] <= 0;
        end
      end
    end
  end

endmodule

//--- verilog/fetch_frontend.sv
////////////////////
// Fetch front end
// Pc table, scheduler, fetch pipeline and buffer
////////////////////
`timescale 1ns/100ps

module fetch_frontend (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    launch_valid,
  output logic                    launch_ready,
  input  warp_fetch_pkg::launch_t launch,
  output logic                    issue_valid,
  input  logic                    issue_ready,
  output warp_fetch_pkg::inst_t   issue
);
  import warp_fetch_pkg::*;

  logic [warp_num-1:0]      active;
  logic [warp_num-1:0]      last;
  logic [warp_num-1:0]      available;
  pc_t  [warp_num-1:0]      pcs;
  logic                     req_valid;
  logic                     req_ready;
  fetch_req_t               req;
  logic                     done_valid;
  fetch_done_t              done;

  warp_pc_table u_pc_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .launch_valid (launch_valid),
    .launch_ready (launch_ready),
    .launch       (launch),
    .done_valid   (done_valid),
    .done         (done),
    .active       (active),
    .last         (last),
    .pcs          (pcs)
  );

  fetch_scheduler u_scheduler (
    .clk        (clk),
    .rst_n      (rst_n),
    .active     (active),
    .last       (last),
    .pcs        (pcs),
    .available  (available),
    .done_valid (done_valid),
    .done_warp  (done.warp),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req)
  );

  // Done pulse goes to the table, the scheduler and the buffer
  inst_fetch u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .done_valid (done_valid),
    .done       (done)
  );

  inst_buffer u_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .done_valid  (done_valid),
    .done        (done),
    .available   (available),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue       (issue)
  );

endmodule

//--- verilog/inst_buffer.sv
////////////////////
// Instruction buffer
// Per-warp FIFOs feeding one fixed-priority issue port
////////////////////
`timescale 1ns/100ps

module inst_buffer (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                done_valid,
  input  warp_fetch_pkg::fetch_done_t         done,
  output logic [warp_fetch_pkg::warp_num-1:0] available,
  output logic                                issue_valid,
  input  logic                                issue_ready,
  output warp_fetch_pkg::inst_t               issue
);
  import warp_fetch_pkg::*;

  typedef logic [$clog2(buf_depth)-1:0]   ptr_t;
  typedef logic [$clog2(buf_depth+1)-1:0] fcnt_t;

  inst_t                  mem_q [warp_num][buf_depth];
  ptr_t  [warp_num-1:0]   wr_ptr_q;
  ptr_t  [warp_num-1:0]   rd_ptr_q;
  fcnt_t [warp_num-1:0]   cnt_q;
  logic  [warp_num-1:0]   not_empty;
  logic                   hold_q;
  warp_num_t              hold_warp_q;
  warp_num_t              prio_warp;
  warp_num_t              sel;
  logic                   pop;

  always_comb begin
    for (int w = 0; w < warp_num; w++) begin
      not_empty[w] = (cnt_q[w] != '0);
      available[w] = (cnt_q[w] < fcnt_t'(buf_depth));
    end
  end

  // Lowest non-empty warp wins
  always_comb begin
    prio_warp = '0;
    for (int w = warp_num - 1; w >= 0; w--) begin
      if (not_empty[w]) begin
        prio_warp = warp_num_t'(w);
      end
    end
  end

  // Stalled offer stays on the same warp
  assign sel         = hold_q ? hold_warp_q : prio_warp;
  assign issue_valid = |not_empty;
  assign issue       = mem_q[sel][rd_ptr_q[sel]];
  assign pop         = issue_valid && issue_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      cnt_q       <= '0;
      hold_q      <= 1'b0;
      hold_warp_q <= '0;
    end else begin
      for (int w = 0; w < warp_num; w++) begin
        logic push_w;
        logic pop_w;
        push_w = done_valid && done.warp == warp_num_t'(w);
        pop_w  = pop && sel == warp_num_t'(w);
        if (push_w) begin
          wr_ptr_q[w] <= (wr_ptr_q[w] == ptr_t'(buf_depth - 1)) ? '0 : wr_ptr_q[w] + 1'b1;
        end
        if (pop_w) begin
          rd_ptr_q[w] <= (rd_ptr_q[w] == ptr_t'(buf_depth - 1)) ? '0 : rd_ptr_q[w] + 1'b1;
        end
        // Push and pop together leave the count alone
        if (push_w && !pop_w) begin
          cnt_q[w] <= cnt_q[w] + 1'b1;
        end else if (pop_w && !push_w) begin
          cnt_q[w] <= cnt_q[w] - 1'b1;
        end
      end
      if (issue_valid && !issue_ready) begin
        hold_q      <= 1'b1;
        hold_warp_q <= sel;
      end else if (pop) begin
        hold_q <= 1'b0;
      end
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (done_valid) begin
      mem_q[done.warp][wr_ptr_q[done.warp]] <= done.inst;
    end
  end

endmodule

//--- verilog/inst_fetch.sv
////////////////////
// Instruction fetch
// Two-stage read of the modeled instruction memory
////////////////////
`timescale 1ns/100ps

module inst_fetch (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_valid,
  output logic                        req_ready,
  input  warp_fetch_pkg::fetch_req_t  req,
  output logic                        done_valid,
  output warp_fetch_pkg::fetch_done_t done
);
  import warp_fetch_pkg::*;

  logic       s1_valid;
  fetch_req_t s1_req;
  inst_t      word;

  // Pipeline never stalls
  assign req_ready = 1'b1;

  // Memory stand-in, word is a function of the pc
  always_comb begin
    word.warp = s1_req.warp;
    word.pc   = s1_req.pc;
    word.imm  = ~s1_req.pc[11:0];
    if (s1_req.last) begin
      word.opcode = op_exit;
    end else begin
      case (s1_req.pc[3:2])
        2'd1:    word.opcode = op_mem;
        2'd2:    word.opcode = op_ctrl;
        // 0 and 3 both map to alu
        default: word.opcode = op_alu;
      endcase
    end
  end

  // Stage valids
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      done_valid <= 1'b0;
    end else begin
      s1_valid   <= req_valid && req_ready;
      done_valid <= s1_valid;
    end
  end

  // Stage one takes the request, stage two the formed word
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      s1_req <= req;
    end
    if (s1_valid) begin
      done.warp <= s1_req.warp;
      done.inst <= word;
    end
  end

endmodule

//--- verilog/fetch_scheduler.sv
////////////////////
// Fetch scheduler
// Round-robin warp pick, one fetch in flight per warp
////////////////////
`timescale 1ns/100ps

module fetch_scheduler (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [warp_fetch_pkg::warp_num-1:0]                 active,
  input  logic [warp_fetch_pkg::warp_num-1:0]                 last,
  input  warp_fetch_pkg::pc_t [warp_fetch_pkg::warp_num-1:0]  pcs,
  input  logic [warp_fetch_pkg::warp_num-1:0]                 available,
  input  logic                                                done_valid,
  input  warp_fetch_pkg::warp_num_t                           done_warp,
  output logic                                                req_valid,
  input  logic                                                req_ready,
  output warp_fetch_pkg::fetch_req_t                          req
);
  import warp_fetch_pkg::*;

  sched_state_e        state_q;
  warp_num_t           last_grant_q;
  warp_num_t           next_warp;
  logic                next_found;
  logic [warp_num-1:0] disabled_q;
  logic [warp_num-1:0] eligible;

  // Running, room in its FIFO, nothing in flight
  assign eligible = active & available & ~disabled_q;

  // Search starts one past the last grant
  always_comb begin : rr_search
    warp_num_t cand;
    next_found = 1'b0;
    next_warp  = last_grant_q;
    for (int i = 1; i <= warp_num; i++) begin
      cand = warp_num_t'(int'(last_grant_q) + i);
      if (!next_found && eligible[cand]) begin
        next_found = 1'b1;
        next_warp  = cand;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= pick_warp;
      req_valid    <= 1'b0;
      last_grant_q <= warp_num_t'(warp_num - 1);
      disabled_q   <= '0;
    end else begin
      case (state_q)
        pick_warp: begin
          if (next_found) begin
            req_valid <= 1'b1;
            state_q   <= wait_accept;
          end
        end
        wait_accept: begin
          // Request held until taken
          if (req_ready) begin
            req_valid    <= 1'b0;
            last_grant_q <= req.warp;
            state_q      <= pick_warp;
          end
        end
        default: begin
          state_q <= pick_warp;
        end
      endcase
      // Fetch landed, warp may go again
      if (done_valid) begin
        disabled_q[done_warp] <= 1'b0;
      end
      // Granted warp is parked until its done
      if (req_valid && req_ready) begin
        disabled_q[req.warp] <= 1'b1;
      end
    end
  end

  // Request payload, latched at the pick
  always_ff @(posedge clk) begin
    if (state_q == pick_warp && next_found) begin
      req.warp <= next_warp;
      req.pc   <= pcs[next_warp];
      req.last <= last[next_warp];
    end
  end

endmodule

//--- verilog/warp_pc_table.sv
////////////////////
// Warp pc table
// Per-warp pc and remaining count, launch and advance on fetch
////////////////////
`timescale 1ns/100ps

module warp_pc_table (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                launch_valid,
  output logic                                                launch_ready,
  input  warp_fetch_pkg::launch_t                             launch,
  input  logic                                                done_valid,
  input  warp_fetch_pkg::fetch_done_t                         done,
  output logic [warp_fetch_pkg::warp_num-1:0]                 active,
  output logic [warp_fetch_pkg::warp_num-1:0]                 last,
  output warp_fetch_pkg::pc_t [warp_fetch_pkg::warp_num-1:0]  pcs
);
  import warp_fetch_pkg::*;

  logic [warp_num-1:0][cnt_width-1:0] cnt_q;
  logic                               launch_fire;

  // A busy warp holds off its own relaunch
  assign launch_ready = !active[launch.warp];
  assign launch_fire  = launch_valid && launch_ready;

  // Final instruction of each running warp
  always_comb begin
    for (int w = 0; w < warp_num; w++) begin
      last[w] = active[w] && (cnt_q[w] == cnt_width'(1));
    end
  end

  // Active flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= '0;
    end else begin
      for (int w = 0; w < warp_num; w++) begin
        if (launch_fire && launch.warp == warp_num_t'(w)) begin
          // Zero-length launch finishes at once
          active[w] <= (launch.count != '0);
        end else if (done_valid && done.warp == warp_num_t'(w) &&
                     cnt_q[w] == cnt_width'(1)) begin
          active[w] <= 1'b0;
        end
      end
    end
  end

  // Pc and count per warp
  always_ff @(posedge clk) begin
    for (int w = 0; w < warp_num; w++) begin
      if (launch_fire && launch.warp == warp_num_t'(w)) begin
        pcs[w]   <= launch.start_pc;
        cnt_q[w] <= launch.count;
      end else if (done_valid && done.warp == warp_num_t'(w)) begin
        // Step to next word
        pcs[w]   <= pcs[w] + pc_t'(4);
        cnt_q[w] <= cnt_q[w] - cnt_width'(1);
      end
    end
  end

endmodule

//--- verilog/warp_fetch_pkg.sv
////////////////////
// Warp fetch package
// Sizes, types and encodings shared by the SIMT fetch front end
////////////////////
package warp_fetch_pkg;

  // Core sizes
  localparam int warp_num  = 4;
  localparam int buf_depth = 2;
  localparam int pc_width  = 16;
  localparam int cnt_width = 6;

  typedef logic [$clog2(warp_num)-1:0] warp_num_t;
  typedef logic [pc_width-1:0] pc_t;

  typedef enum logic [1:0] {
    op_alu,
    op_mem,
    op_ctrl,
    op_exit
  } opcode_e;

  // Instruction word rule, applied by the fetch unit
  // Last instruction of a warp gets op_exit
  // Otherwise pc[3:2] picks 0 alu, 1 mem, 2 ctrl, 3 alu again
  // Immediate is the inverted low 12 pc bits
  typedef struct packed {
    opcode_e     opcode;
    warp_num_t   warp;
    logic [11:0] imm;
    pc_t         pc;
  } inst_t;

  typedef struct packed {
    warp_num_t            warp;
    pc_t                  start_pc;
    logic [cnt_width-1:0] count;
  } launch_t;

  // Last flag rides along so the fetch unit can form op_exit
  typedef struct packed {
    warp_num_t warp;
    pc_t       pc;
    logic      last;
  } fetch_req_t;

  typedef struct packed {
    warp_num_t warp;
    inst_t     inst;
  } fetch_done_t;

  typedef enum logic {
    pick_warp,
    wait_accept
  } sched_state_e;

endpackage
